/* src.f */
+incdir+include
logic/la_cfg_pkg.sv
logic/la_cmd_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/sample_ram.sv
logic/capture_engine.sv
logic/la_sequencer.sv
logic/logic_analyzer_top.sv
testbench/tb_logic_analyzer.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_logic_analyzer -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -Fqx "Test completed successfully" <<< "$sim_out"; then
    exit 0
fi
exit 1

/* include/tb_uart_tasks.svh */
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// serial helpers for the including module
// it declares clk, dut_rx into the DUT and dut_tx out of it

// wait until the DUT output idles high, then drive one 8N1 frame on dut_rx
task automatic uart_send(input la_cmd_pkg::byte_t data, input int bit_cycles,
                         input int timeout, output bit ok);
    int         waited;
    logic [9:0] frame;
    waited = 0;
    frame  = {1'b1, data, 1'b0};                // stop, data lsb first, start
    while (dut_tx !== 1'b1 && waited < timeout) begin
        @(posedge clk);
        waited++;
    end
    ok = (dut_tx === 1'b1);                     // host talks only on a quiet line
    if (ok) begin
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            dut_rx = frame[i];                  // change 1 ns after the edge
            repeat (bit_cycles - 1) @(posedge clk);
        end
    end
endtask

// wait for a start bit on dut_tx, then sample each bit in its middle
task automatic uart_recv(output la_cmd_pkg::byte_t data, input int bit_cycles,
                         input int timeout, output bit ok);
    int waited;
    waited = 0;
    data   = '0;
    while (dut_tx !== 1'b0 && waited < timeout) begin
        @(posedge clk);
        waited++;
    end
    ok = (dut_tx === 1'b0);
    if (ok) begin
        repeat (bit_cycles / 2) @(posedge clk);   // mid start bit
        for (int i = 0; i < 8; i++) begin
            repeat (bit_cycles) @(posedge clk);
            data[i] = dut_tx;
        end
        repeat (bit_cycles) @(posedge clk);
        ok = (dut_tx === 1'b1);                 // framing check on the stop bit
    end
endtask

`endif

/* testbench/tb_logic_analyzer.sv */
`timescale 1ns/1ps

module tb_logic_analyzer;
    import la_cfg_pkg::*;
    import la_cmd_pkg::*;

    localparam int          ADDR_W       = 8;
    localparam int          BAUD_DIV     = 16;
    localparam int          DEPTH        = 2 ** ADDR_W;
    localparam int          RESP_LEN     = PTR_BYTES + DEPTH;   // pointer, then whole buffer
    localparam byte_t       POST_BYTE    = 8'd4;
    localparam int          POST_SAMPLES = int'(POST_BYTE) << POST_SHIFT;   // 64 samples
    localparam int          PRE_OFFSET   = 70;                  // past the post window
    localparam int          SEND_TIMEOUT = 100;                 // cycles for the DUT line to idle
    localparam int          RESP_TIMEOUT = 40000;               // capture plus first byte
    localparam int          BYTE_GAP     = 20 * BAUD_DIV;       // idle time ends a response
    localparam int          QUIET_WINDOW = 4096;
    localparam logic [31:0] RAND_SEED    = 32'h18232e75;

    logic    clk;
    logic    rst_n;
    logic    dut_rx;                            // host to DUT
    logic    dut_tx;                            // DUT to host
    sample_t io;
    sample_t pat_a;                             // bit 0 low
    sample_t pat_b;                             // bit 0 high
    byte_t   resp[$];                           // last response, in arrival order
    int      checks;
    int      errors;

    `include "tb_uart_tasks.svh"

    logic_analyzer_top #(.ADDR_W(ADDR_W), .BAUD_DIV(BAUD_DIV)) i_logic_analyzer_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .uart_rx_i (dut_rx),
        .uart_tx_o (dut_tx),
        .io_i      (io)
    );

    always #10 clk = ~clk;                      // 20 ns period

    task automatic compare_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic confirm(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic drive_io(input sample_t value);
        @(posedge clk);
        #1;
        io = value;                             // 1 ns after the edge
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic send_command(input byte_t mask, input byte_t pol, input byte_t prescale,
                                input byte_t post);
        byte_t frame [FRAME_LEN];
        bit    ok;
        frame[IDX_MASK]     = mask;
        frame[IDX_POL]      = pol;
        frame[IDX_PRESCALE] = prescale;
        frame[IDX_POST]     = post;
        for (int i = 0; i < FRAME_LEN; i++) begin
            uart_send(frame[i], BAUD_DIV, SEND_TIMEOUT, ok);
            confirm(ok, "DUT serial output was not idle high when a command byte was due");
        end
    endtask

    // gathers bytes until the line stays quiet
    // stops at one byte past the expected length
    task automatic collect_response(input int first_timeout);
        byte_t b;
        bit    ok;
        resp.delete();
        ok = 1'b1;
        while (ok && resp.size() <= RESP_LEN) begin
            uart_recv(b, BAUD_DIV, (resp.size() == 0) ? first_timeout : BYTE_GAP, ok);
            if (ok) begin
                resp.push_back(b);
            end
        end
    endtask

    // p is the trigger slot
    // p+1 on holds post samples and p+70 an older one
    task automatic check_capture(input string name);
        int p;
        compare_value({name, " byte count"}, RESP_LEN, resp.size());
        if (resp.size() == RESP_LEN) begin
            p = int'(resp[0]);
            compare_value({name, " pointer high byte"}, 0, int'(resp[1]));
            for (int k = 1; k < POST_SAMPLES; k++) begin
                compare_value({name, " post trigger sample"}, int'(pat_b),
                              int'(resp[PTR_BYTES + ((p + k) % DEPTH)]));
            end
            compare_value({name, " pre trigger sample"}, int'(pat_a),
                          int'(resp[PTR_BYTES + ((p + PRE_OFFSET) % DEPTH)]));
        end
    endtask

    task automatic run_capture(input string name, input byte_t prescale);
        drive_io(pat_a);
        send_command(8'h01, 8'h01, prescale, POST_BYTE);
        repeat (DEPTH * (int'(prescale) + 1) * 2) @(posedge clk);   // ring fills twice
        drive_io(pat_b);                        // rising bit 0 fires the trigger
        collect_response(RESP_TIMEOUT);
        check_capture(name);
    endtask

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        dut_rx = 1'b1;                          // serial idle
        io     = '0;
        checks = 0;
        errors = 0;
        void'($urandom(RAND_SEED));
        pat_a = sample_t'($urandom()) & 8'hfe;
        pat_b = sample_t'($urandom()) | 8'h01;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        run_capture("framing", 8'd0);
        run_capture("prescale", 8'd3);

        // polarity 0 with a rising pin must never trigger
        drive_io(pat_a);
        send_command(8'h01, 8'h00, 8'h00, POST_BYTE);
        repeat (DEPTH * 2) @(posedge clk);
        drive_io(pat_b);
        collect_response(QUIET_WINDOW);
        compare_value("polarity byte count", 0, resp.size());
        apply_reset();                          // capture is still armed

        // post 0 ends the capture at once
        drive_io(pat_a);
        send_command(8'h01, 8'h01, 8'h00, 8'h00);
        collect_response(RESP_TIMEOUT);
        compare_value("zero post byte count", RESP_LEN, resp.size());
        if (resp.size() >= PTR_BYTES) begin
            compare_value("zero post pointer low byte", 0, int'(resp[0]));
            compare_value("zero post pointer high byte", 0, int'(resp[1]));
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* logic/logic_analyzer_top.sv */
`timescale 1ns/1ps

module logic_analyzer_top #(
    parameter int ADDR_W   = la_cfg_pkg::ADDR_W_DEF,
    parameter int BAUD_DIV = la_cfg_pkg::BAUD_DIV_DEF
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                uart_rx_i,
    output logic                uart_tx_o,
    input  la_cfg_pkg::sample_t io_i
);
    import la_cfg_pkg::*;
    import la_cmd_pkg::*;

    logic              rx_valid;
    byte_t             rx_byte;
    logic              tx_start;
    byte_t             tx_byte;
    logic              tx_busy;
    logic              cap_start;
    logic              cap_busy;                // also selects the ram port owner
    sample_t           mask;
    sample_t           pol;
    byte_t             prescale;
    byte_t             post;
    logic [ADDR_W-1:0] trig_ptr;
    logic              we;
    logic [ADDR_W-1:0] waddr;
    sample_t           wdata;
    logic [ADDR_W-1:0] rd_addr;
    sample_t           rdata;

    uart_rx #(.BAUD_DIV(BAUD_DIV)) i_uart_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_i       (uart_rx_i),
        .rx_valid_o (rx_valid),
        .rx_byte_o  (rx_byte)
    );

    uart_tx #(.BAUD_DIV(BAUD_DIV)) i_uart_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_start_i (tx_start),
        .tx_byte_i  (tx_byte),
        .tx_o       (uart_tx_o),
        .tx_busy_o  (tx_busy)
    );

    la_sequencer #(.ADDR_W(ADDR_W)) i_la_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_valid_i  (rx_valid),
        .rx_byte_i   (rx_byte),
        .tx_busy_i   (tx_busy),
        .tx_start_o  (tx_start),
        .tx_byte_o   (tx_byte),
        .cap_busy_i  (cap_busy),
        .trig_ptr_i  (trig_ptr),
        .cap_start_o (cap_start),
        .mask_o      (mask),
        .pol_o       (pol),
        .prescale_o  (prescale),
        .post_o      (post),
        .rd_addr_o   (rd_addr),
        .rdata_i     (rdata)
    );

    capture_engine #(.ADDR_W(ADDR_W)) i_capture_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .io_i        (io_i),
        .cap_start_i (cap_start),
        .mask_i      (mask),
        .pol_i       (pol),
        .prescale_i  (prescale),
        .post_i      (post),
        .cap_busy_o  (cap_busy),
        .trig_ptr_o  (trig_ptr),
        .we_o        (we),
        .waddr_o     (waddr),
        .wdata_o     (wdata)
    );

    sample_ram #(.ADDR_W(ADDR_W)) i_sample_ram (
        .clk       (clk),
        .we_i      (we),
        .wr_addr_i (waddr),
        .rd_addr_i (rd_addr),
        .sel_wr_i  (cap_busy),
        .wdata_i   (wdata),
        .rdata_o   (rdata)
    );

endmodule

/* logic/la_sequencer.sv */
`timescale 1ns/1ps

module la_sequencer #(
    parameter int ADDR_W = la_cfg_pkg::ADDR_W_DEF
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rx_valid_i,
    input  la_cmd_pkg::byte_t   rx_byte_i,
    input  logic                tx_busy_i,
    output logic                tx_start_o,
    output la_cmd_pkg::byte_t   tx_byte_o,
    input  logic                cap_busy_i,
    input  logic [ADDR_W-1:0]   trig_ptr_i,
    output logic                cap_start_o,
    output la_cfg_pkg::sample_t mask_o,
    output la_cfg_pkg::sample_t pol_o,
    output la_cmd_pkg::byte_t   prescale_o,
    output la_cmd_pkg::byte_t   post_o,
    output logic [ADDR_W-1:0]   rd_addr_o,
    input  la_cfg_pkg::sample_t rdata_i
);
    import la_cmd_pkg::*;

    localparam int IDX_W = $clog2(FRAME_LEN);
    localparam int PTR_W = PTR_BYTES * BYTE_W;

    typedef enum logic [2:0] {
        S_COLLECT,                              // gather the command bytes
        S_START,
        S_WAIT_CAP,
        S_PTR_LO,
        S_PTR_HI,
        S_READ,                                 // ram latency cycle
        S_SEND
    } state_t;

    state_t           state_q;
    byte_t            frame_q [FRAME_LEN];      // command bytes as received
    logic [IDX_W-1:0] idx_q;                    // next frame slot
    logic [PTR_W-1:0] ptr_ext;                  // zero extended trigger pointer
    logic             tx_ready;

    // fields stay put from S_START until the next command
    assign mask_o     = frame_q[IDX_MASK];
    assign pol_o      = frame_q[IDX_POL];
    assign prescale_o = frame_q[IDX_PRESCALE];
    assign post_o     = frame_q[IDX_POST];

    assign ptr_ext  = PTR_W'(trig_ptr_i);
    assign tx_ready = !tx_busy_i && !tx_start_o;   // busy lags start by a cycle

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= S_COLLECT;
            idx_q       <= '0;
            tx_start_o  <= 1'b0;
            cap_start_o <= 1'b0;
            rd_addr_o   <= '0;
        end else begin
            tx_start_o  <= 1'b0;                // both are single pulses
            cap_start_o <= 1'b0;
            case (state_q)
                S_COLLECT: begin
                    if (rx_valid_i) begin
                        frame_q[idx_q] <= rx_byte_i;
                        idx_q          <= idx_q + 1'b1;
                        if (idx_q == IDX_W'(FRAME_LEN - 1)) begin
                            state_q <= S_START;
                        end
                    end
                end
                S_START: begin
                    cap_start_o <= 1'b1;
                    idx_q       <= '0;
                    state_q     <= S_WAIT_CAP;
                end
                S_WAIT_CAP: begin
                    if (!cap_busy_i && !cap_start_o) begin   // skip the pulse cycle
                        state_q <= S_PTR_LO;
                    end
                end
                S_PTR_LO: begin
                    if (tx_ready) begin
                        tx_start_o <= 1'b1;
                        tx_byte_o  <= ptr_ext[BYTE_W-1:0];
                        state_q    <= S_PTR_HI;
                    end
                end
                S_PTR_HI: begin
                    if (tx_ready) begin
                        tx_start_o <= 1'b1;
                        tx_byte_o  <= ptr_ext[BYTE_W +: BYTE_W];
                        rd_addr_o  <= '0;       // dump starts at address 0
                        state_q    <= S_READ;
                    end
                end
                S_READ: begin
                    state_q <= S_SEND;
                end
                S_SEND: begin
                    if (tx_ready) begin
                        tx_start_o <= 1'b1;
                        tx_byte_o  <= rdata_i;
                        if (rd_addr_o == '1) begin   // whole buffer sent
                            state_q <= S_COLLECT;
                        end else begin
                            rd_addr_o <= rd_addr_o + 1'b1;
                            state_q   <= S_READ;
                        end
                    end
                end
                default: state_q <= S_COLLECT;
            endcase
        end
    end

endmodule

/* logic/capture_engine.sv */
`timescale 1ns/1ps

module capture_engine #(
    parameter int ADDR_W = la_cfg_pkg::ADDR_W_DEF
) (
    input  logic                clk,
    input  logic                rst_n,
    input  la_cfg_pkg::sample_t io_i,
    input  logic                cap_start_i,
    input  la_cfg_pkg::sample_t mask_i,
    input  la_cfg_pkg::sample_t pol_i,
    input  la_cmd_pkg::byte_t   prescale_i,
    input  la_cmd_pkg::byte_t   post_i,
    output logic                cap_busy_o,
    output logic [ADDR_W-1:0]   trig_ptr_o,
    output logic                we_o,
    output logic [ADDR_W-1:0]   waddr_o,
    output la_cfg_pkg::sample_t wdata_o
);
    import la_cfg_pkg::*;
    import la_cmd_pkg::*;

    localparam int POST_W = BYTE_W + POST_SHIFT;

    sample_t           io_q;                    // io one clock ago
    byte_t             pre_cnt_q;               // prescale counter
    logic [POST_W-1:0] post_cnt_q;              // samples left after trigger
    logic              triggered_q;
    logic              pin_changed;             // a masked pin toggled
    logic              pin_matches;             // a masked pin sits at its polarity
    logic              trig_ev;
    logic              trig_now;                // trigger seen, incl. this cycle
    logic              sample_now;

    assign pin_changed = |((io_i ^ io_q) & mask_i);
    assign pin_matches = |(~(io_i ^ pol_i) & mask_i);
    assign trig_ev     = cap_busy_o & pin_changed & pin_matches;
    assign trig_now    = triggered_q | trig_ev;
    assign sample_now  = (pre_cnt_q == prescale_i);
    assign wdata_o     = io_q;                  // sample taken on the edge that set we_o

    always_ff @(posedge clk) begin
        io_q <= io_i;
        if (!rst_n) begin
            cap_busy_o  <= 1'b0;
            we_o        <= 1'b0;
            triggered_q <= 1'b0;
            pre_cnt_q   <= '0;
            post_cnt_q  <= '0;
            waddr_o     <= '0;
            trig_ptr_o  <= '0;
        end else if (cap_start_i) begin
            cap_busy_o  <= 1'b1;
            we_o        <= 1'b1;                // first sample goes to address 0
            waddr_o     <= '0;
            pre_cnt_q   <= '0;
            triggered_q <= 1'b0;
            trig_ptr_o  <= '0;                  // stays 0 if no trigger ever fires
            post_cnt_q  <= POST_W'(post_i) << POST_SHIFT;
        end else if (cap_busy_o) begin
            if (post_cnt_q == '0) begin         // last write lands this cycle
                cap_busy_o <= 1'b0;
                we_o       <= 1'b0;
            end else begin
                if (trig_ev && !triggered_q) begin
                    triggered_q <= 1'b1;
                    trig_ptr_o  <= waddr_o;     // last pre trigger slot
                end
                we_o <= sample_now;
                if (sample_now) begin
                    pre_cnt_q <= '0;
                    waddr_o   <= waddr_o + 1'b1;   // wraps around the ring
                    if (trig_now) begin
                        post_cnt_q <= post_cnt_q - 1'b1;   // counts samples, not clocks
                    end
                end else begin
                    pre_cnt_q <= pre_cnt_q + 1'b1;
                end
            end
        end
    end

endmodule

/* logic/sample_ram.sv */
`timescale 1ns/1ps

module sample_ram #(
    parameter int ADDR_W = la_cfg_pkg::ADDR_W_DEF
) (
    input  logic                clk,
    input  logic                we_i,
    input  logic [ADDR_W-1:0]   wr_addr_i,
    input  logic [ADDR_W-1:0]   rd_addr_i,
    input  logic                sel_wr_i,
    input  la_cfg_pkg::sample_t wdata_i,
    output la_cfg_pkg::sample_t rdata_o
);
    import la_cfg_pkg::*;

    sample_t           mem [2**ADDR_W];         // ring buffer storage
    logic [ADDR_W-1:0] addr;                    // the one shared port

    assign addr = sel_wr_i ? wr_addr_i : rd_addr_i;   // capture owns it while busy

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr] <= wdata_i;
        end
        rdata_o <= mem[addr];                   // one cycle read latency
    end

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int BAUD_DIV = la_cfg_pkg::BAUD_DIV_DEF
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              tx_start_i,
    input  la_cmd_pkg::byte_t tx_byte_i,
    output logic              tx_o,
    output logic              tx_busy_o
);
    import la_cfg_pkg::*;
    import la_cmd_pkg::*;

    localparam int FRAME_BITS = BYTE_W + 2;     // start + data + stop

    logic [FRAME_BITS-1:0] frame_q;             // bit 0 is on the line
    logic [BAUD_CNT_W-1:0] cnt_q;               // clocks left in this bit
    logic [3:0]            left_q;              // bits still to shift out

    assign tx_o      = frame_q[0];
    assign tx_busy_o = (left_q != 4'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_q <= '1;                      // idle high
            cnt_q   <= '0;
            left_q  <= '0;
        end else if (left_q == 4'd0) begin
            if (tx_start_i) begin
                frame_q <= {1'b1, tx_byte_i, 1'b0};
                cnt_q   <= BAUD_CNT_W'(BAUD_DIV - 1);
                left_q  <= 4'(FRAME_BITS);
            end
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end else begin
            frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};   // refill with idle
            cnt_q   <= BAUD_CNT_W'(BAUD_DIV - 1);
            left_q  <= left_q - 1'b1;           // busy drops after the stop bit
        end
    end

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
    parameter int BAUD_DIV = la_cfg_pkg::BAUD_DIV_DEF
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rx_i,
    output logic              rx_valid_o,
    output la_cmd_pkg::byte_t rx_byte_o
);
    import la_cfg_pkg::*;
    import la_cmd_pkg::*;

    logic [1:0]            sync_q;              // two flop synchronizer
    logic                  rx_s;                // synchronized line
    logic                  busy_q;              // inside a frame
    logic [BAUD_CNT_W-1:0] cnt_q;               // clocks to next sample point
    logic [3:0]            bit_q;               // 0 start, 1..8 data, 9 stop
    byte_t                 shift_q;             // data bits, lsb first

    assign rx_s      = sync_q[1];
    assign rx_byte_o = shift_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q     <= 2'b11;                // line idles high
            busy_q     <= 1'b0;
            cnt_q      <= '0;
            bit_q      <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            sync_q     <= {sync_q[0], rx_i};
            rx_valid_o <= 1'b0;                 // one cycle strobe
            if (!busy_q) begin
                if (!rx_s) begin                // start edge
                    busy_q <= 1'b1;
                    cnt_q  <= BAUD_CNT_W'(BAUD_DIV / 2 - 1);   // aim at mid start bit
                    bit_q  <= '0;
                end
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end else begin
                cnt_q <= BAUD_CNT_W'(BAUD_DIV - 1);
                bit_q <= bit_q + 1'b1;
                if (bit_q == 4'd0) begin
                    busy_q <= !rx_s;            // glitch, not a real start
                end else if (bit_q == 4'd9) begin
                    busy_q     <= 1'b0;
                    rx_valid_o <= rx_s;         // drop byte on framing error
                end else begin
                    shift_q <= {rx_s, shift_q[BYTE_W-1:1]};
                end
            end
        end
    end

endmodule

/* logic/la_cmd_pkg.sv */
// host command frame and readout framing
package la_cmd_pkg;

    localparam int BYTE_W    = 8;               // uart byte
    localparam int FRAME_LEN = 4;               // bytes per command

    // field position inside the command frame
    localparam int IDX_MASK     = 0;            // trigger mask
    localparam int IDX_POL      = 1;            // trigger polarity
    localparam int IDX_PRESCALE = 2;            // sample every prescale+1 clocks
    localparam int IDX_POST     = 3;            // post trigger count / 16

    localparam int POST_SHIFT = 4;              // post byte x16 = samples
    localparam int PTR_BYTES  = 2;              // trigger pointer bytes, low first

    typedef logic [BYTE_W-1:0] byte_t;

endpackage

/* logic/la_cfg_pkg.sv */
// hardware sizes shared by the capture path and the serial blocks
package la_cfg_pkg;

    localparam int SAMPLE_W     = 8;            // probed io port width
    localparam int ADDR_W_DEF   = 8;            // 256 samples in the ring buffer
    localparam int BAUD_DIV_DEF = 16;           // clocks per bit, short for simulation
    localparam int BAUD_CNT_W   = 16;           // bit period counter width

    // board builds set BAUD_DIV to clock / baud at the top level

    typedef logic [SAMPLE_W-1:0] sample_t;      // one io sample

endpackage
